//--- hdl/torus_pkg.sv
package torus_pkg;

        localparam int AXIS_BITS    = 1;        // Two nodes per ring
        localparam int NUM_NODES    = 8;
        localparam int TAG_BITS     = 8;
        localparam int PAYLOAD_BITS = 32;
        localparam int NUM_PORTS    = 4;        // X, Y, Z and local

        typedef struct packed {
                logic [AXIS_BITS-1:0] x;
                logic [AXIS_BITS-1:0] y;
                logic [AXIS_BITS-1:0] z;
        } coord_t;

        typedef struct packed {
                coord_t                  dst;
                coord_t                  src;
                logic [TAG_BITS-1:0]     tag;
                logic [PAYLOAD_BITS-1:0] payload;
        } flit_t;

        // Output port of a node and index of the matching input
        typedef enum logic [1:0] {
                PORT_X     = 2'd0,
                PORT_Y     = 2'd1,
                PORT_Z     = 2'd2,
                PORT_LOCAL = 2'd3
        } port_e;

endpackage

//--- hdl/input_buffer.sv
`timescale 1ns/1ns

module input_buffer
        import torus_pkg::*;
#(
        parameter coord_t node_pos = '0
) (
        input  logic                 clk,
        input  logic                 rst_n,
        input  flit_t                in_flit,
        input  logic                 in_valid,
        output logic                 in_ready,
        output flit_t                out_flit,
        output logic [NUM_PORTS-1:0] req,
        input  logic                 grant
);

        logic  full;
        port_e route;

        assign in_ready = ~full;                        // Single entry

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        full <= 1'b0;
                end else if (in_valid && in_ready) begin
                        full <= 1'b1;
                end else if (grant) begin
                        full <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (in_valid && in_ready) begin
                        out_flit <= in_flit;
                end
        end

        // Dimension order picks the first differing axis
        always_comb begin
                if (out_flit.dst.x != node_pos.x) begin
                        route = PORT_X;
                end else if (out_flit.dst.y != node_pos.y) begin
                        route = PORT_Y;
                end else if (out_flit.dst.z != node_pos.z) begin
                        route = PORT_Z;
                end else begin
                        route = PORT_LOCAL;             // Arrived
                end
        end

        always_comb begin
                req = '0;
                req[route] = full;                      // One-hot while holding a flit
        end

endmodule

//--- hdl/port_arbiter.sv
`timescale 1ns/1ns

module port_arbiter
        import torus_pkg::*;
(
        input  logic                 clk,
        input  logic                 rst_n,
        input  logic [NUM_PORTS-1:0] req,
        input  flit_t                cand_flit [NUM_PORTS],
        output logic [NUM_PORTS-1:0] grant,
        output flit_t                out_flit,
        output logic                 out_valid,
        input  logic                 out_ready
);

        localparam int sel_bits = $clog2(NUM_PORTS);

        logic [sel_bits-1:0] ptr;
        logic [sel_bits-1:0] win;
        logic                found;
        logic                can_load;
        logic                take;

        // Register empty or draining this edge
        assign can_load = ~out_valid | out_ready;
        assign take     = found & can_load;

        // Search starts at the pointer and wraps
        always_comb begin
                logic [sel_bits-1:0] idx;

                found = 1'b0;
                win   = '0;
                for (int i = 0; i < NUM_PORTS; i++) begin
                        idx = ptr + sel_bits'(i);
                        if (!found && req[idx]) begin
                                found = 1'b1;
                                win   = idx;
                        end
                end
        end

        always_comb begin
                grant = '0;
                grant[win] = take;
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        out_valid <= 1'b0;
                        ptr       <= '0;
                end else if (take) begin
                        out_valid <= 1'b1;
                        ptr       <= win + sel_bits'(1);        // Move past the winner
                end else if (out_ready) begin
                        out_valid <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (take) begin
                        out_flit <= cand_flit[win];
                end
        end

endmodule

//--- hdl/torus_node.sv
`timescale 1ns/1ns

module torus_node
        import torus_pkg::*;
#(
        parameter coord_t node_pos = '0
) (
        input  logic                 clk,
        input  logic                 rst_n,

        input  flit_t                inject_flit,
        input  logic                 inject_valid,
        output logic                 inject_ready,

        output flit_t                eject_flit,
        output logic                 eject_valid,
        input  logic                 eject_ready,

        input  flit_t                link_in_flit   [NUM_PORTS-1],
        input  logic [NUM_PORTS-2:0] link_in_valid,
        output logic [NUM_PORTS-2:0] link_in_ready,
        output flit_t                link_out_flit  [NUM_PORTS-1],
        output logic [NUM_PORTS-2:0] link_out_valid,
        input  logic [NUM_PORTS-2:0] link_out_ready
);

        wire flit_t            in_flit   [NUM_PORTS];
        wire [NUM_PORTS-1:0]   in_valid;
        wire [NUM_PORTS-1:0]   in_ready;
        wire flit_t            out_flit  [NUM_PORTS];
        wire [NUM_PORTS-1:0]   out_valid;
        wire [NUM_PORTS-1:0]   out_ready;

        flit_t                 buf_flit  [NUM_PORTS];
        logic [NUM_PORTS-1:0]  buf_req   [NUM_PORTS];   // Indexed by buffer
        logic [NUM_PORTS-1:0]  req_col   [NUM_PORTS];   // Indexed by arbiter
        logic [NUM_PORTS-1:0]  arb_grant [NUM_PORTS];
        logic [NUM_PORTS-1:0]  buf_grant;

        // Turn buffer requests into arbiter columns and OR the grants back
        always_comb begin
                for (int b = 0; b < NUM_PORTS; b++) begin
                        buf_grant[b] = 1'b0;
                        for (int p = 0; p < NUM_PORTS; p++) begin
                                req_col[p][b] = buf_req[b][p];
                                buf_grant[b]  = buf_grant[b] | arb_grant[p][b];
                        end
                end
        end

        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
                if (p == PORT_LOCAL) begin : g_local
                        assign in_flit[p]   = inject_flit;
                        assign in_valid[p]  = inject_valid;
                        assign inject_ready = in_ready[p];
                        assign eject_flit   = out_flit[p];
                        assign eject_valid  = out_valid[p];
                        assign out_ready[p] = eject_ready;
                end else begin : g_link
                        assign in_flit[p]        = link_in_flit[p];
                        assign in_valid[p]       = link_in_valid[p];
                        assign link_in_ready[p]  = in_ready[p];
                        assign link_out_flit[p]  = out_flit[p];
                        assign link_out_valid[p] = out_valid[p];
                        assign out_ready[p]      = link_out_ready[p];
                end

                input_buffer #(
                        .node_pos (node_pos)
                ) input_buffer_i (
                        .clk      (clk),
                        .rst_n    (rst_n),
                        .in_flit  (in_flit[p]),
                        .in_valid (in_valid[p]),
                        .in_ready (in_ready[p]),
                        .out_flit (buf_flit[p]),
                        .req      (buf_req[p]),
                        .grant    (buf_grant[p])
                );

                port_arbiter port_arbiter_i (
                        .clk       (clk),
                        .rst_n     (rst_n),
                        .req       (req_col[p]),
                        .cand_flit (buf_flit),
                        .grant     (arb_grant[p]),
                        .out_flit  (out_flit[p]),
                        .out_valid (out_valid[p]),
                        .out_ready (out_ready[p])
                );
        end

endmodule

//--- hdl/torus_network.sv
`timescale 1ns/1ns

module torus_network
        import torus_pkg::*;
(
        input  logic                 clk,
        input  logic                 rst_n,

        input  flit_t                inject_flit  [NUM_NODES],
        input  logic [NUM_NODES-1:0] inject_valid,
        output logic [NUM_NODES-1:0] inject_ready,

        output flit_t                eject_flit   [NUM_NODES],
        output logic [NUM_NODES-1:0] eject_valid,
        input  logic [NUM_NODES-1:0] eject_ready
);

        // One link each way per node and axis since each ring has two nodes
        wire flit_t              lo_flit  [NUM_NODES][NUM_PORTS-1];
        wire [NUM_PORTS-2:0]     lo_valid [NUM_NODES];
        wire [NUM_PORTS-2:0]     lo_ready [NUM_NODES];
        wire flit_t              li_flit  [NUM_NODES][NUM_PORTS-1];
        wire [NUM_PORTS-2:0]     li_valid [NUM_NODES];
        wire [NUM_PORTS-2:0]     li_ready [NUM_NODES];

        for (genvar n = 0; n < NUM_NODES; n++) begin : g_node
                // Neighbour in axis a differs in bit a of the node number
                for (genvar a = 0; a < NUM_PORTS - 1; a++) begin : g_axis
                        assign li_flit[n][a]  = lo_flit[n ^ (1 << a)][a];
                        assign li_valid[n][a] = lo_valid[n ^ (1 << a)][a];
                        assign lo_ready[n][a] = li_ready[n ^ (1 << a)][a];
                end

                torus_node #(
                        .node_pos ('{x: AXIS_BITS'(n % 2),
                                     y: AXIS_BITS'((n / 2) % 2),
                                     z: AXIS_BITS'((n / 4) % 2)})
                ) torus_node_i (
                        .clk            (clk),
                        .rst_n          (rst_n),
                        .inject_flit    (inject_flit[n]),
                        .inject_valid   (inject_valid[n]),
                        .inject_ready   (inject_ready[n]),
                        .eject_flit     (eject_flit[n]),
                        .eject_valid    (eject_valid[n]),
                        .eject_ready    (eject_ready[n]),
                        .link_in_flit   (li_flit[n]),
                        .link_in_valid  (li_valid[n]),
                        .link_in_ready  (li_ready[n]),
                        .link_out_flit  (lo_flit[n]),
                        .link_out_valid (lo_valid[n]),
                        .link_out_ready (lo_ready[n])
                );
        end

endmodule

//--- verif/tb_torus_network.sv
`timescale 1ns/1ns

module tb_torus_network
        import torus_pkg::*;
();

        localparam int MAX_CASES     = 64;
        localparam int SETTLE_CYCLES = 20;

        logic                 clk;
        logic                 rst_n;
        flit_t                inject_flit [NUM_NODES];
        logic [NUM_NODES-1:0] inject_valid;
        logic [NUM_NODES-1:0] inject_ready;
        flit_t                eject_flit  [NUM_NODES];
        logic [NUM_NODES-1:0] eject_valid;
        logic [NUM_NODES-1:0] eject_ready;

        logic [31:0]             case_mem     [MAX_CASES*4];        // Four words per case
        logic [2:0]              case_src     [MAX_CASES];
        logic [2:0]              case_dst     [MAX_CASES];
        logic [TAG_BITS-1:0]     case_tag     [MAX_CASES];
        logic [PAYLOAD_BITS-1:0] case_payload [MAX_CASES];
        int                      pair_q       [NUM_NODES*NUM_NODES][$]; // Case indices per pair
        int                      num_cases;
        int                      received;
        int                      errors;
        int                      checks;
        logic                    started;
        logic [31:0]             lcg_state;

        torus_network torus_network_i (
                .clk          (clk),
                .rst_n        (rst_n),
                .inject_flit  (inject_flit),
                .inject_valid (inject_valid),
                .inject_ready (inject_ready),
                .eject_flit   (eject_flit),
                .eject_valid  (eject_valid),
                .eject_ready  (eject_ready)
        );

        function automatic coord_t node_coord(input logic [2:0] n);
                coord_t c;
                c.x = n[0];
                c.y = n[1];
                c.z = n[2];
                return c;
        endfunction

        function automatic int node_number(input coord_t c);
                return int'({c.z, c.y, c.x});
        endfunction

        function automatic flit_t make_flit(input int idx);
                flit_t f;
                f.dst     = node_coord(case_dst[idx]);
                f.src     = node_coord(case_src[idx]);
                f.tag     = case_tag[idx];
                f.payload = case_payload[idx];
                return f;
        endfunction

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("ERROR %s got %h expected %h", name, got, exp);
                end
        endtask

        task automatic receive_flit(input int node, input flit_t f);
                int src;
                int idx;
                src = node_number(f.src);
                received++;
                if (pair_q[src*NUM_NODES + node].size() == 0) begin
                        errors++;
                        $display("Unexpected flit at node %0d from node %0d with tag %h",
                                 node, src, f.tag);
                end else begin
                        idx = pair_q[src*NUM_NODES + node].pop_front();      // Oldest first
                        check($sformatf("eject_flit[%0d].dst", node), 64'(f.dst),
                              64'(node_coord(case_dst[idx])));
                        check($sformatf("eject_flit[%0d].tag", node), 64'(f.tag),
                              64'(case_tag[idx]));
                        check($sformatf("eject_flit[%0d].payload", node), 64'(f.payload),
                              64'(case_payload[idx]));
                end
        endtask

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        for (genvar s = 0; s < NUM_NODES; s++) begin : g_inject
                initial begin
                        inject_flit[s]  = '0;
                        inject_valid[s] = 1'b0;
                        wait (started);
                        for (int i = 0; i < num_cases; i++) begin
                                if (case_src[i] == 3'(s)) begin
                                        inject_flit[s]  = make_flit(i);
                                        inject_valid[s] = 1'b1;
                                        @(negedge clk);
                                        while (!inject_ready[s]) @(negedge clk);
                                        @(posedge clk);                 // Accepted here
                                        #1;
                                        inject_valid[s] = 1'b0;
                                end
                        end
                end
        end

        // Random back-pressure on the eject ports
        initial begin
                eject_ready = '0;
                lcg_state   = 32'd9;
                wait (started);
                forever begin
                        @(posedge clk);
                        #1;
                        for (int n = 0; n < NUM_NODES; n++) begin
                                lcg_state      = lcg_next(lcg_state);
                                eject_ready[n] = lcg_state[31:30] != 2'b00;
                        end
                end
        end

        // Sampled mid-cycle, so valid and ready show what the next edge does
        initial begin
                logic [NUM_NODES-1:0] held;
                flit_t                held_flit [NUM_NODES];
                held = '0;
                forever begin
                        @(negedge clk);
                        for (int n = 0; n < NUM_NODES; n++) begin
                                if (started && held[n]) begin
                                        check($sformatf("eject_valid[%0d]", n),
                                              64'(eject_valid[n]), 64'(1));
                                        check($sformatf("eject_flit[%0d]", n),
                                              64'(eject_flit[n]), 64'(held_flit[n]));
                                end
                                held[n]      = eject_valid[n] && !eject_ready[n];
                                held_flit[n] = eject_flit[n];
                                if (started && eject_valid[n] && eject_ready[n]) begin
                                        receive_flit(n, eject_flit[n]);
                                end
                        end
                end
        end

        initial begin
                int limit;
                int missing;
                wait (started);
                limit = num_cases * 40 + 200;
                repeat (limit) @(posedge clk);
                missing = 0;
                $display("Timeout after %0d cycles, %0d of %0d flits received",
                         limit, received, num_cases);
                for (int p = 0; p < NUM_NODES*NUM_NODES; p++) begin
                        for (int k = 0; k < pair_q[p].size(); k++) begin
                                missing++;
                                $display("Missing flit: case %0d from node %0d to node %0d, tag %h",
                                         pair_q[p][k], p / NUM_NODES, p % NUM_NODES,
                                         case_tag[pair_q[p][k]]);
                        end
                end
                $display("Checks: %0d, errors: %0d, missing flits: %0d", checks, errors, missing);
                $display("Finished with errors");
                $finish;
        end

        initial begin
                errors   = 0;
                checks   = 0;
                received = 0;
                started  = 1'b0;
                rst_n    = 1'b0;
                for (int i = 0; i < MAX_CASES*4; i++) begin
                        case_mem[i] = 32'hffff_0000 | 32'(i);   // No valid node number
                end
                $readmemh("verif/torus_cases.txt", case_mem);
                num_cases = 0;
                while (num_cases < MAX_CASES && case_mem[4*num_cases] < 32'd8) begin
                        if (case_mem[4*num_cases+1] >= 32'd8) begin
                                errors++;
                                $display("Case %0d has a destination outside the network",
                                         num_cases);
                        end
                        case_src[num_cases]     = case_mem[4*num_cases][2:0];
                        case_dst[num_cases]     = case_mem[4*num_cases+1][2:0];
                        case_tag[num_cases]     = case_mem[4*num_cases+2][TAG_BITS-1:0];
                        case_payload[num_cases] = case_mem[4*num_cases+3];
                        pair_q[int'(case_src[num_cases])*NUM_NODES +
                               int'(case_dst[num_cases])].push_back(num_cases);
                        num_cases++;
                end
                if (num_cases == 0) begin
                        errors++;
                        $display("No cases could be read from verif/torus_cases.txt");
                end
                repeat (16) @(posedge clk);
                #1;
                rst_n = 1'b1;
                @(negedge clk);
                for (int n = 0; n < NUM_NODES; n++) begin
                        check($sformatf("eject_valid[%0d]", n), 64'(eject_valid[n]), 64'(0));
                        check($sformatf("inject_ready[%0d]", n), 64'(inject_ready[n]), 64'(1));
                end
                @(posedge clk);
                #1;
                started = 1'b1;
                wait (received >= num_cases);
                repeat (SETTLE_CYCLES) @(posedge clk);          // Catch late extra flits
                $display("Checks: %0d, errors: %0d, flits received: %0d of %0d",
                         checks, errors, received, num_cases);
                if (errors == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

//--- verif/torus_cases.txt
// Columns in hex: source node, destination node, tag, payload
// Each source injects its own lines in file order
0 6 01 a0000001
1 6 02 a1000002
2 6 03 a2000003
3 6 04 a3000004
4 6 05 a4000005
5 6 06 a5000006
6 6 07 a6000007
7 6 08 a7000008
0 0 09 00c0ffee
5 5 0a 5555aaaa
7 7 0b 77777777
0 1 0c 01010101
0 2 0d 02020202
0 4 0e 04040404
3 2 0f 32323232
6 7 10 67676767
0 3 11 deadbeef
2 4 12 24242424
5 3 13 53535353
0 7 14 07070707
1 6 15 16161616
2 5 16 25252525
4 3 17 43434343
3 5 18 35000001
3 5 19 35000002
3 5 1a 35000003
6 1 1b 61000001
6 1 1c 61000002

//--- filelist.f
hdl/torus_pkg.sv
hdl/input_buffer.sv
hdl/port_arbiter.sv
hdl/torus_node.sv
hdl/torus_network.sv
verif/tb_torus_network.sv

//--- run_sim.sh
#!/bin/sh
# Build the torus testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_torus_network \
        -f filelist.f -o tb_torus_network > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
        cat "$BUILD_LOG"
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/tb_torus_network > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -q "Finished with errors" "$SIM_LOG"; then
        echo "Simulation FAILED"
        exit 1
fi
echo "Simulation PASSED"
exit 0
